/* include/sad_settings.svh */
`ifndef SAD_SETTINGS_SVH
`define SAD_SETTINGS_SVH

// window length, also the number of staggered lanes
`define SAD_LANES            8

// raw adc sample width
`define SAD_SAMPLE_BITS      12

// sad sum and threshold width
// 8 samples of 4095 add up to 32760, which fits in 16 bits
`define SAD_SUM_BITS         16

// apb register map
`define SAD_ADDR_REF0        8'h00    // reference i sits at REF0 + 4*i
`define SAD_ADDR_THRESHOLD   8'h20
`define SAD_ADDR_STATUS      8'h24    // bit 0 triggered, write 1 to clear

// apb data bus width
`define SAD_APB_DATA_BITS    32

// apb address width
`define SAD_APB_ADDR_BITS    8

`endif

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module sad_trigger_tb -f sad_trigger.f

out=$(./obj_dir/Vsad_trigger_tb) || {
    echo "$out"
    exit 1
}
echo "$out"
echo "$out" | grep -qx "PASS: all tests"

/* sad_trigger.f */
+incdir+include
source/sad_pkg.sv
source/sad_regs.sv
source/sad_lane.sv
source/sad_control.sv
source/sad_trigger.sv
tb/tb_clock.sv
tb/sad_trigger_assert.sv
tb/sad_trigger_tb.sv

/* source/sad_control.sv */
`default_nettype none

`include "sad_settings.svh"

module sad_control (
    input  wire                    adc_sampleclk,
    input  wire                    reset,
    input  wire                    arm,
    input  wire  [`SAD_LANES-1:0]  hits,
    output logic                   run,
    output logic                   trigger
);
    import sad_pkg::*;

    ctrl_state_t state;
    ctrl_state_t state_next;
    logic        trigger_next;
    logic        any_hit;

    assign any_hit = |hits;

    // lanes run only while the fsm is in RUNNING
    assign run = (state == RUNNING);

    always_comb begin
        state_next   = state;
        trigger_next = 1'b0;
        case (state)
            IDLE: begin
                if (arm) begin
                    state_next = RUNNING;
                end
            end

            RUNNING: begin
                // disarm beats a hit in the same cycle
                if (!arm) begin
                    state_next = IDLE;
                end else if (any_hit) begin
                    trigger_next = 1'b1;
                    state_next   = DONE;
                end
            end

            DONE: begin
                // hold here until software drops arm
                if (!arm) begin
                    state_next = IDLE;
                end
            end

            default: begin
                state_next = IDLE;
            end
        endcase
    end

    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            state   <= IDLE;
            trigger <= 1'b0;
        end else begin
            state   <= state_next;
            trigger <= trigger_next;   // one cycle, fsm leaves RUNNING with it
        end
    end

endmodule

`default_nettype wire

/* source/sad_lane.sv */
`default_nettype none

`include "sad_settings.svh"

// One lane per phase of the window. Lane i waits i cycles after run rises,
// then walks the reference index 0..7 over and over, so every sample k
// is compared against reference (k - i) mod 8. A lane therefore finishes
// a full window every 8 samples, and the 8 lanes together cover every
// window position in the stream.
module sad_lane #(
    parameter int LANE = 0
) (
    input  wire                  adc_sampleclk,
    input  wire                  reset,
    input  wire                  run,
    input  wire sad_pkg::sample_t adc_datain,
    input  wire sad_pkg::sample_t ref_samples [`SAD_LANES],
    input  wire sad_pkg::sad_t   threshold,
    output logic                 hit
);
    import sad_pkg::*;

    localparam lane_idx_t START    = lane_idx_t'(LANE);
    localparam lane_idx_t LAST_IDX = lane_idx_t'(`SAD_LANES - 1);

    lane_idx_t delay_cnt;    // start offset counter
    lane_idx_t ref_idx;
    logic      active;
    sample_t   ref_sel;
    sample_t   abs_diff;

    sample_t   diff_r;
    logic      diff_valid;
    logic      diff_first;   // diff belongs to reference 0
    logic      diff_last;    // diff belongs to reference 7

    sad_t      sum;
    logic      sum_done;

    assign active  = run && (delay_cnt == START);
    assign ref_sel = ref_samples[ref_idx];

    assign abs_diff = (adc_datain > ref_sel) ? (adc_datain - ref_sel)
                                             : (ref_sel - adc_datain);

    // stage 0: start delay, reference index, sample capture
    always_ff @(posedge adc_sampleclk) begin
        if (reset || !run) begin
            delay_cnt  <= '0;
            ref_idx    <= '0;
            diff_valid <= 1'b0;
            diff_first <= 1'b0;
            diff_last  <= 1'b0;
        end else begin
            diff_valid <= active;
            diff_first <= active && (ref_idx == '0);
            diff_last  <= active && (ref_idx == LAST_IDX);
            if (!active) begin
                delay_cnt <= delay_cnt + 1'b1;
            end else begin
                ref_idx <= ref_idx + 1'b1;   // wraps 7 -> 0
            end
        end
    end

    always_ff @(posedge adc_sampleclk) begin
        diff_r <= abs_diff;
    end

    // stage 1: accumulate, restart on reference 0
    always_ff @(posedge adc_sampleclk) begin
        if (reset || !run) begin
            sum      <= '0;
            sum_done <= 1'b0;
        end else begin
            sum_done <= diff_valid && diff_last;
            if (diff_valid) begin
                if (diff_first) begin
                    sum <= sad_t'(diff_r);
                end else begin
                    sum <= sum + sad_t'(diff_r);
                end
            end
        end
    end

    // stage 2: compare a complete window against the threshold
    always_ff @(posedge adc_sampleclk) begin
        if (reset || !run) begin
            hit <= 1'b0;
        end else begin
            hit <= sum_done && (sum <= threshold);
        end
    end

endmodule

`default_nettype wire

/* source/sad_pkg.sv */
`default_nettype none

`include "sad_settings.svh"

package sad_pkg;

    // one adc or reference sample
    typedef logic [`SAD_SAMPLE_BITS-1:0] sample_t;

    // window sum, also used for the threshold
    typedef logic [`SAD_SUM_BITS-1:0] sad_t;

    // position inside the reference window
    typedef logic [$clog2(`SAD_LANES)-1:0] lane_idx_t;

    // arm fsm
    typedef enum logic [1:0] {
        IDLE    = 2'd0,   // waiting for arm
        RUNNING = 2'd1,   // lanes comparing
        DONE    = 2'd2    // fired, waiting for arm to drop
    } ctrl_state_t;

endpackage

`default_nettype wire

/* source/sad_regs.sv */
`default_nettype none

`include "sad_settings.svh"

module sad_regs (
    input  wire                                  adc_sampleclk,
    input  wire                                  reset,

    input  wire                                  psel,
    input  wire                                  penable,
    input  wire                                  pwrite,
    input  wire  [`SAD_APB_ADDR_BITS-1:0]        paddr,
    input  wire  [`SAD_APB_DATA_BITS-1:0]        pwdata,
    output logic [`SAD_APB_DATA_BITS-1:0]        prdata,
    output logic                                 pready,
    output logic                                 pslverr,

    input  wire                                  trigger,
    output sad_pkg::sample_t                     ref_samples [`SAD_LANES],
    output sad_pkg::sad_t                        threshold
);
    import sad_pkg::*;

    logic      wr_en;
    logic      rd_en;
    logic      triggered;
    logic      status_clear;
    sample_t   wr_sample;
    sad_t      wr_threshold;

    // address of reference sample idx
    function automatic logic [`SAD_APB_ADDR_BITS-1:0] ref_addr(input int idx);
        return `SAD_ADDR_REF0 + (`SAD_APB_ADDR_BITS)'(4 * idx);
    endfunction

    // access phase of an apb transfer, never stretched
    assign wr_en = psel && penable && pwrite;
    assign rd_en = psel && penable && !pwrite;

    assign pready  = 1'b1;
    assign pslverr = 1'b0;

    assign wr_sample    = pwdata[`SAD_SAMPLE_BITS-1:0];
    assign wr_threshold = pwdata[`SAD_SUM_BITS-1:0];

    assign status_clear = wr_en && (paddr == `SAD_ADDR_STATUS) && pwdata[0];

    // reference and threshold writes
    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            for (int i = 0; i < `SAD_LANES; i++) begin
                ref_samples[i] <= '0;
            end
            threshold <= '0;
        end else if (wr_en) begin
            for (int i = 0; i < `SAD_LANES; i++) begin
                if (paddr == ref_addr(i)) begin
                    ref_samples[i] <= wr_sample;
                end
            end
            if (paddr == `SAD_ADDR_THRESHOLD) begin
                threshold <= wr_threshold;
            end
        end
    end

    // sticky triggered bit
    // a trigger in the same cycle as the clear wins so no event is lost
    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            triggered <= 1'b0;
        end else if (trigger) begin
            triggered <= 1'b1;
        end else if (status_clear) begin
            triggered <= 1'b0;
        end
    end

    // read mux, only driven during the access cycle
    always_comb begin
        prdata = '0;
        if (rd_en) begin
            for (int i = 0; i < `SAD_LANES; i++) begin
                if (paddr == ref_addr(i)) begin
                    prdata = (`SAD_APB_DATA_BITS)'(ref_samples[i]);
                end
            end
            if (paddr == `SAD_ADDR_THRESHOLD) begin
                prdata = (`SAD_APB_DATA_BITS)'(threshold);
            end
            if (paddr == `SAD_ADDR_STATUS) begin
                prdata = {{(`SAD_APB_DATA_BITS-1){1'b0}}, triggered};
            end
        end
    end

endmodule

`default_nettype wire

/* source/sad_trigger.sv */
`default_nettype none

`include "sad_settings.svh"

module sad_trigger (
    input  wire                                  adc_sampleclk,
    input  wire                                  reset,

    // apb slave
    input  wire                                  psel,
    input  wire                                  penable,
    input  wire                                  pwrite,
    input  wire  [`SAD_APB_ADDR_BITS-1:0]        paddr,
    input  wire  [`SAD_APB_DATA_BITS-1:0]        pwdata,
    output logic [`SAD_APB_DATA_BITS-1:0]        prdata,
    output logic                                 pready,
    output logic                                 pslverr,

    input  wire sad_pkg::sample_t                adc_datain,
    input  wire                                  arm,
    output logic                                 trigger
);
    import sad_pkg::*;

    sample_t                 ref_samples [`SAD_LANES];
    sad_t                    threshold;
    logic                    run;
    logic [`SAD_LANES-1:0]   hits;

    sad_regs sad_regs_i (
        .adc_sampleclk (adc_sampleclk),
        .reset         (reset),
        .psel          (psel),
        .penable       (penable),
        .pwrite        (pwrite),
        .paddr         (paddr),
        .pwdata        (pwdata),
        .prdata        (prdata),
        .pready        (pready),
        .pslverr       (pslverr),
        .trigger       (trigger),
        .ref_samples   (ref_samples),
        .threshold     (threshold)
    );

    // one lane per window phase
    for (genvar i = 0; i < `SAD_LANES; i++) begin : g_lane
        sad_lane #(
            .LANE (i)
        ) sad_lane_i (
            .adc_sampleclk (adc_sampleclk),
            .reset         (reset),
            .run           (run),
            .adc_datain    (adc_datain),
            .ref_samples   (ref_samples),
            .threshold     (threshold),
            .hit           (hits[i])
        );
    end

    sad_control sad_control_i (
        .adc_sampleclk (adc_sampleclk),
        .reset         (reset),
        .arm           (arm),
        .hits          (hits),
        .run           (run),
        .trigger       (trigger)
    );

endmodule

`default_nettype wire

/* tb/sad_trigger_assert.sv */
`default_nettype none

module sad_trigger_assert (
    input wire adc_sampleclk,
    input wire reset,
    input wire trigger,
    input wire pready,
    input wire pslverr
);
    timeunit 1ns;
    timeprecision 100ps;

    // trigger is a single cycle pulse
    trigger_one_cycle: assert property (
        @(posedge adc_sampleclk) disable iff (reset)
        trigger |=> !trigger
    ) else $error("trigger high for two cycles in a row");

    // apb slave never stalls and never errors
    apb_no_wait_no_error: assert property (
        @(posedge adc_sampleclk)
        pready && !pslverr
    ) else $error("pready low or pslverr high");

    // synchronous reset clears the trigger register
    trigger_low_after_reset: assert property (
        @(posedge adc_sampleclk)
        reset |=> !trigger
    ) else $error("trigger not low in the cycle after reset");

endmodule

`default_nettype wire

/* tb/sad_trigger_tb.sv */
`default_nettype none

`include "sad_settings.svh"

module sad_trigger_tb;
    timeunit 1ns;
    timeprecision 100ps;

    typedef logic [`SAD_SAMPLE_BITS-1:0]   sample_word_t;
    typedef logic [`SAD_SUM_BITS-1:0]      sum_word_t;
    typedef logic [`SAD_APB_ADDR_BITS-1:0] apb_addr_t;
    typedef logic [`SAD_APB_DATA_BITS-1:0] apb_word_t;

    localparam int DRIVE_DELAY  = 10;
    localparam int SAMPLE_DELAY = 40;   // prdata read mid access cycle
    localparam int PIPE_EDGES   = 3;    // capture edge to trigger edge
    localparam int NO_PATTERN   = -1;
    localparam int RAND_OFFSET  = -2;
    localparam int NUM_TESTS    = 7;

    // threshold, pattern offset, noise, stream length, trigger expected
    localparam int TEST_THRESHOLD [NUM_TESTS] = '{0, 0, 150, 0, 40, 0, 1000};
    localparam int TEST_OFFSET    [NUM_TESTS] = '{RAND_OFFSET, 0, 30, NO_PATTERN,
                                                  RAND_OFFSET, 24, NO_PATTERN};
    localparam int TEST_NOISE     [NUM_TESTS] = '{0, 0, 15, 0, 4, 0, 0};
    localparam int TEST_LEN       [NUM_TESTS] = '{40, 16, 64, 48, 50, 32, 40};
    localparam int TEST_FIRES     [NUM_TESTS] = '{1, 1, 1, 0, 1, 1, 0};

    // reset plus register test, then apb traffic and drain per test
    localparam int SETUP_CYCLES    = 100;
    localparam int CYCLES_PER_TEST = 40;

    logic         adc_sampleclk;
    logic         reset;
    logic         psel;
    logic         penable;
    logic         pwrite;
    apb_addr_t    paddr;
    apb_word_t    pwdata;
    apb_word_t    prdata;
    logic         pready;
    logic         pslverr;
    sample_word_t adc_datain;
    logic         arm;
    logic         trigger;

    sample_word_t ref_vals [`SAD_LANES];
    sample_word_t stream [$];
    int           errors = 0;
    int           tests_failed = 0;
    bit           verdict_printed = 1'b0;   // set once a closing message went out

    tb_clock tb_clock_i (
        .adc_sampleclk (adc_sampleclk),
        .reset         (reset)
    );

    sad_trigger sad_trigger_i (
        .adc_sampleclk (adc_sampleclk),
        .reset         (reset),
        .psel          (psel),
        .penable       (penable),
        .pwrite        (pwrite),
        .paddr         (paddr),
        .pwdata        (pwdata),
        .prdata        (prdata),
        .pready        (pready),
        .pslverr       (pslverr),
        .adc_datain    (adc_datain),
        .arm           (arm),
        .trigger       (trigger)
    );

    bind sad_trigger sad_trigger_assert sad_trigger_assert_i (
        .adc_sampleclk (adc_sampleclk),
        .reset         (reset),
        .trigger       (trigger),
        .pready        (pready),
        .pslverr       (pslverr)
    );

    task automatic next_cycle();
        @(posedge adc_sampleclk);
        #DRIVE_DELAY;
    endtask

    task automatic apb_write(input apb_addr_t addr, input apb_word_t data);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        next_cycle();
        penable = 1'b1;   // write lands on this access edge
        next_cycle();
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_read(input apb_addr_t addr, output apb_word_t data);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        next_cycle();
        penable = 1'b1;
        #SAMPLE_DELAY;
        data = prdata;
        next_cycle();
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    function automatic apb_addr_t reference_address(input int idx);
        return apb_addr_t'(`SAD_ADDR_REF0 + 4 * idx);
    endfunction

    task automatic report_mismatch(input string name, input apb_word_t got,
                                   input apb_word_t exp);
        $display("MISMATCH %s: got 0x%0h, expected 0x%0h", name, got, exp);
        errors++;
    endtask

    task automatic finish_test(input int num, input string kind, input int start_errors,
                               input string note);
        if (errors > start_errors) begin
            tests_failed++;
            $display("test %0d %s: failed, %0d errors", num, kind, errors - start_errors);
        end else begin
            $display("test %0d %s: ok%s", num, kind, note);
        end
    endtask

    // embedded pattern sample with uniform noise, clipped to the adc range
    function automatic sample_word_t add_noise(input sample_word_t value, input int amp);
        int v;
        v = int'(value);
        if (amp > 0) begin
            v = v + int'($urandom % (2 * amp + 1)) - amp;
        end
        if (v < 0) begin
            v = 0;
        end
        if (v > (1 << `SAD_SAMPLE_BITS) - 1) begin
            v = (1 << `SAD_SAMPLE_BITS) - 1;
        end
        return sample_word_t'(v);
    endfunction

    // window starting at sample s is compared with references 0..7 in order
    function automatic int window_sad(input int start);
        int acc;
        int diff;
        acc = 0;
        for (int j = 0; j < `SAD_LANES; j++) begin
            diff = int'(stream[start + j]) - int'(ref_vals[j]);
            acc += (diff < 0) ? -diff : diff;
        end
        return acc;
    endfunction

    function automatic int first_window(input int len, input int thr);
        for (int s = 0; s + `SAD_LANES <= len; s++) begin
            if (window_sad(s) <= thr) begin
                return s;
            end
        end
        return NO_PATTERN;
    endfunction

    function automatic string test_kind(input int t);
        if (TEST_OFFSET[t] == NO_PATTERN) begin
            return "no match";
        end
        return (TEST_NOISE[t] == 0) ? "exact match" : "noisy match";
    endfunction

    task automatic register_test();
        apb_word_t wr;
        apb_word_t rd;
        apb_word_t exp_refs [`SAD_LANES];
        int        start_errors;
        start_errors = errors;
        apb_read(`SAD_ADDR_STATUS, rd);
        if (rd !== '0) begin
            report_mismatch("status", rd, '0);
        end
        for (int j = 0; j < `SAD_LANES; j++) begin
            wr = $urandom;
            exp_refs[j] = apb_word_t'(sample_word_t'(wr));   // upper bits dropped
            apb_write(reference_address(j), wr);
        end
        wr = $urandom;
        apb_write(`SAD_ADDR_THRESHOLD, wr);
        for (int j = 0; j < `SAD_LANES; j++) begin
            apb_read(reference_address(j), rd);
            if (rd !== exp_refs[j]) begin
                report_mismatch($sformatf("ref[%0d]", j), rd, exp_refs[j]);
            end
        end
        apb_read(`SAD_ADDR_THRESHOLD, rd);
        if (rd !== apb_word_t'(sum_word_t'(wr))) begin
            report_mismatch("threshold", rd, apb_word_t'(sum_word_t'(wr)));
        end
        apb_write(apb_addr_t'(`SAD_ADDR_STATUS + 4), $urandom);   // word past status
        apb_read(apb_addr_t'(`SAD_ADDR_STATUS + 4), rd);
        if (rd !== '0) begin
            report_mismatch("unmapped", rd, '0);
        end
        apb_read(apb_addr_t'(`SAD_ADDR_REF0 + 1), rd);
        if (rd !== '0) begin
            report_mismatch("misaligned", rd, '0);
        end
        finish_test(0, "register readback", start_errors, "");
    endtask

    task automatic pattern_test(input int t);
        int        len;
        int        offset;
        int        first_win;
        int        exp_cycle;
        int        start_errors;
        apb_word_t rd;
        apb_word_t exp_status;
        start_errors = errors;
        len = TEST_LEN[t];
        for (int j = 0; j < `SAD_LANES; j++) begin
            ref_vals[j] = sample_word_t'($urandom);
            apb_write(reference_address(j), apb_word_t'(ref_vals[j]));
        end
        apb_write(`SAD_ADDR_THRESHOLD, apb_word_t'(TEST_THRESHOLD[t]));

        stream.delete();
        for (int n = 0; n < len; n++) begin
            stream.push_back(sample_word_t'($urandom));
        end
        offset = TEST_OFFSET[t];
        if (offset == RAND_OFFSET) begin
            offset = int'($urandom % (len - `SAD_LANES + 1));
        end
        if (offset >= 0) begin
            for (int j = 0; j < `SAD_LANES; j++) begin
                stream[offset + j] = add_noise(ref_vals[j], TEST_NOISE[t]);
            end
        end

        // last sample s+7 captured at edge s+8, trigger three edges later
        first_win = first_window(len, TEST_THRESHOLD[t]);
        exp_cycle = (first_win < 0) ? -1 : first_win + `SAD_LANES + PIPE_EDGES;
        if ((first_win >= 0) != (TEST_FIRES[t] != 0)) begin
            $display("test %0d: table and window model disagree on a trigger", t + 1);
            errors++;
        end

        arm = 1'b1;
        next_cycle();   // run starts on this edge
        for (int n = 0; n <= len + PIPE_EDGES + 2; n++) begin
            adc_datain = (n < len) ? stream[n] : sample_word_t'($urandom);
            if (n == exp_cycle) begin
                if (trigger !== 1'b1) begin
                    $display("trigger missing at cycle %0d after run start", n);
                    errors++;
                end
            end else if (trigger !== 1'b0) begin
                $display("unexpected trigger at cycle %0d, expected at %0d", n, exp_cycle);
                errors++;
            end
            if (n == len + PIPE_EDGES) begin
                arm = 1'b0;   // windows past the stream end never fire
            end
            next_cycle();
        end
        adc_datain = '0;

        exp_status = apb_word_t'(first_win >= 0);
        apb_read(`SAD_ADDR_STATUS, rd);
        if (rd !== exp_status) begin
            report_mismatch("status", rd, exp_status);
        end
        if (exp_status != '0) begin
            apb_write(`SAD_ADDR_STATUS, apb_word_t'(1));
            apb_read(`SAD_ADDR_STATUS, rd);
            if (rd !== '0) begin
                report_mismatch("status after clear", rd, '0);
            end
        end
        finish_test(t + 1, test_kind(t), start_errors, (first_win < 0) ? ", no trigger" :
                    $sformatf(", trigger at cycle %0d", exp_cycle));
    endtask

    initial begin
        int limit;
        int cycles;
        limit = SETUP_CYCLES;
        for (int t = 0; t < NUM_TESTS; t++) begin
            limit += TEST_LEN[t] + CYCLES_PER_TEST;
        end
        cycles = 0;
        while (cycles < limit) begin
            @(posedge adc_sampleclk);
            cycles++;
        end
        $display("timeout: run still going after %0d clock cycles", limit);
        verdict_printed = 1'b1;
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        void'($urandom(92));
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        paddr      = '0;
        pwdata     = '0;
        adc_datain = '0;
        arm        = 1'b0;
        wait (reset === 1'b0);
        next_cycle();

        register_test();
        for (int t = 0; t < NUM_TESTS; t++) begin
            pattern_test(t);
            next_cycle();
        end

        $display("tests run %0d, passed %0d, failed %0d, errors %0d", NUM_TESTS + 1,
                 NUM_TESTS + 1 - tests_failed, tests_failed, errors);
        verdict_printed = 1'b1;
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    // a failed assertion stops the run before the summary
    final begin
        if (!verdict_printed) begin
            $display("FAIL: see errors above");
        end
    end

endmodule

`default_nettype wire

/* tb/tb_clock.sv */
`default_nettype none

module tb_clock (
    output logic adc_sampleclk,
    output logic reset
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int HALF_PERIOD  = 50;   // 100 ns sample clock
    localparam int RESET_CYCLES = 2;
    localparam int DRIVE_DELAY  = 10;

    initial begin
        adc_sampleclk = 1'b0;
        forever #HALF_PERIOD adc_sampleclk = ~adc_sampleclk;
    end

    // reset held over the first two rising edges
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge adc_sampleclk);
        #DRIVE_DELAY reset = 1'b0;
    end

endmodule

`default_nettype wire
